// ==== common/muldiv_pkg.sv ====
//--------------------------------------------------------------------------
// muldiv shared definitions
// operand width, divider step count and the opcode and state enums
//--------------------------------------------------------------------------
`default_nettype none

package muldiv_pkg;

    localparam int XLEN      = 32;                 // operand and result width
    localparam int DIV_STEPS = 32;                 // one quotient bit per step
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);  // step counter width

    // function codes follow the RV32M funct3 field
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } muldiv_op_e;

    typedef enum logic [1:0] {
        CTRL_IDLE = 2'd0,
        CTRL_MUL  = 2'd1,  // waiting on the multiplier
        CTRL_DIV  = 2'd2   // waiting on the divider
    } ctrl_state_e;

    typedef enum logic [1:0] {
        MUL_IDLE = 2'd0,
        MUL_EXEC = 2'd1,
        MUL_RET  = 2'd2
    } mul_state_e;

    typedef enum logic [1:0] {
        DIV_IDLE  = 2'd0,
        DIV_CHECK = 2'd1,  // zero test and magnitude conversion
        DIV_EXEC  = 2'd2,
        DIV_RET   = 2'd3
    } div_state_e;

endpackage

`default_nettype wire

// ==== hw/muldiv/muldiv_ctrl.sv ====
//--------------------------------------------------------------------------
// muldiv control
// accepts one operation, starts the matching core and merges the results
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module muldiv_ctrl import muldiv_pkg::*; (
    input  wire              clk_i,
    input  wire              rst,
    input  wire              valid_i,
    input  wire muldiv_op_e  op_i,
    input  wire              mul_done_i,
    input  wire              div_done_i,
    input  wire [XLEN-1:0]   mul_rslt_i,
    input  wire [XLEN-1:0]   div_rslt_i,
    output logic             mul_start_o,
    output logic             mul_src1_signed_o,
    output logic             mul_src2_signed_o,
    output logic             mul_high_o,
    output logic             div_start_o,
    output logic             div_signed_o,
    output logic             div_rem_o,
    output logic             busy_o,
    output logic             done_o,
    output logic [XLEN-1:0]  rslt_o
);

    ctrl_state_e state_r;
    logic        accept;  // idle and requested
    logic        is_div;

    assign is_div      = op_i[2];  // funct3 msb picks the divider
    assign accept      = (state_r == CTRL_IDLE) && valid_i;
    assign mul_start_o = accept && !is_div;
    assign div_start_o = accept && is_div;

    //----------------------------------------------------------------------
    // operand flags per function code
    //----------------------------------------------------------------------
    always_comb begin
        mul_src1_signed_o = 1'b0;
        mul_src2_signed_o = 1'b0;
        mul_high_o        = 1'b0;
        div_signed_o      = 1'b0;
        div_rem_o         = 1'b0;
        case (op_i)
            OP_MULH: begin
                mul_src1_signed_o = 1'b1;
                mul_src2_signed_o = 1'b1;
                mul_high_o        = 1'b1;
            end
            OP_MULHSU: begin
                mul_src1_signed_o = 1'b1;  // rs2 stays unsigned
                mul_high_o        = 1'b1;
            end
            OP_MULHU: mul_high_o = 1'b1;
            OP_DIV:   div_signed_o = 1'b1;
            OP_REM: begin
                div_signed_o = 1'b1;
                div_rem_o    = 1'b1;
            end
            OP_REMU:  div_rem_o = 1'b1;
            default:  ;  // OP_MUL, OP_DIVU
        endcase
    end

    //----------------------------------------------------------------------
    // busy tracking
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst) begin
            state_r <= CTRL_IDLE;
        end else begin
            case (state_r)
                CTRL_IDLE: begin
                    if (mul_start_o) state_r <= CTRL_MUL;
                    else if (div_start_o) state_r <= CTRL_DIV;
                end
                CTRL_MUL: if (mul_done_i) state_r <= CTRL_IDLE;
                CTRL_DIV: if (div_done_i) state_r <= CTRL_IDLE;
                default:  state_r <= CTRL_IDLE;
            endcase
        end
    end

    assign busy_o = (state_r != CTRL_IDLE);  // holds through the done cycle
    assign done_o = mul_done_i | div_done_i;
    assign rslt_o = mul_rslt_i | div_rslt_i;  // idle core drives zero

endmodule

`default_nettype wire

// ==== hw/muldiv/mul_core.sv ====
//--------------------------------------------------------------------------
// two-step multiplier on 33-bit sign-extended operands
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module mul_core import muldiv_pkg::*; (
    input  wire              clk_i,
    input  wire              rst,
    input  wire              start_i,
    input  wire              src1_signed_i,
    input  wire              src2_signed_i,
    input  wire              high_i,
    input  wire [XLEN-1:0]   src1_i,
    input  wire [XLEN-1:0]   src2_i,
    output logic             done_o,
    output logic [XLEN-1:0]  rslt_o
);

    mul_state_e                state_r;
    logic signed [XLEN:0]      mcand_r;    // 33 bit
    logic signed [XLEN:0]      mplier_r;   // 33 bit
    logic                      high_r;
    logic [2*XLEN-1:0]         prod_r;
    logic signed [2*XLEN+1:0]  full_prod;  // upper two bits are sign copies

    assign full_prod = mcand_r * mplier_r;

    always_ff @(posedge clk_i) begin
        if (rst) begin
            state_r <= MUL_IDLE;
        end else begin
            case (state_r)
                MUL_IDLE: if (start_i) state_r <= MUL_EXEC;
                MUL_EXEC: state_r <= MUL_RET;
                default:  state_r <= MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_r == MUL_IDLE && start_i) begin
            mcand_r  <= {src1_signed_i && src1_i[XLEN-1], src1_i};
            mplier_r <= {src2_signed_i && src2_i[XLEN-1], src2_i};
            high_r   <= high_i;
        end
        if (state_r == MUL_EXEC) begin
            prod_r <= full_prod[2*XLEN-1:0];
        end
    end

    assign done_o = (state_r == MUL_RET);
    assign rslt_o = (!done_o) ? '0 :
                    (high_r)  ? prod_r[2*XLEN-1:XLEN] : prod_r[XLEN-1:0];

endmodule

`default_nettype wire

// ==== hw/muldiv/div_core.sv ====
//--------------------------------------------------------------------------
// sequential restoring divider
// magnitude conversion, zero divisor path and result sign correction
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module div_core import muldiv_pkg::*; (
    input  wire              clk_i,
    input  wire              rst,
    input  wire              start_i,
    input  wire              signed_i,
    input  wire              rem_i,
    input  wire [XLEN-1:0]   src1_i,
    input  wire [XLEN-1:0]   src2_i,
    output logic             done_o,
    output logic [XLEN-1:0]  rslt_o
);

    div_state_e            state_r;
    logic                  dvd_neg_r;  // dividend negative
    logic                  dvs_neg_r;  // divisor negative
    logic                  quo_neg_r;
    logic                  rem_neg_r;
    logic                  rem_sel_r;  // return remainder
    logic [XLEN-1:0]       rem_r;
    logic [XLEN-1:0]       quo_r;
    logic [XLEN-1:0]       dvs_r;
    logic [DIV_CNT_W-1:0]  cnt_r;

    logic [XLEN-1:0]       dvd_mag;
    logic [XLEN-1:0]       dvs_mag;
    logic                  dvs_zero;
    logic [XLEN:0]         shifted;    // partial remainder with next dividend bit
    logic [XLEN+1:0]       diff;
    logic                  q_bit;
    logic [XLEN-1:0]       quo_out;
    logic [XLEN-1:0]       rem_out;

    assign dvd_mag  = (dvd_neg_r) ? (~rem_r + XLEN'(1)) : rem_r;  // rem_r holds dividend
    assign dvs_mag  = (dvs_neg_r) ? (~dvs_r + XLEN'(1)) : dvs_r;
    assign dvs_zero = (dvs_r == '0);
    assign shifted  = {rem_r, quo_r[XLEN-1]};
    assign diff     = {1'b0, shifted} - {2'b00, dvs_r};
    assign q_bit    = !diff[XLEN+1];  // no borrow

    //----------------------------------------------------------------------
    // state machine
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst) begin
            state_r <= DIV_IDLE;
        end else begin
            case (state_r)
                DIV_IDLE:  if (start_i) state_r <= DIV_CHECK;
                DIV_CHECK: state_r <= (dvs_zero) ? DIV_RET : DIV_EXEC;
                DIV_EXEC:  if (cnt_r == '0) state_r <= DIV_RET;
                default:   state_r <= DIV_IDLE;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // datapath
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        case (state_r)
            DIV_IDLE: begin
                if (start_i) begin
                    rem_sel_r <= rem_i;
                    dvd_neg_r <= signed_i && src1_i[XLEN-1];
                    dvs_neg_r <= signed_i && src2_i[XLEN-1];
                    quo_neg_r <= signed_i && (src1_i[XLEN-1] ^ src2_i[XLEN-1]);
                    rem_neg_r <= signed_i && src1_i[XLEN-1];  // follows the dividend
                    rem_r     <= src1_i;
                    quo_r     <= '0;
                    dvs_r     <= src2_i;
                end
            end
            DIV_CHECK: begin
                if (dvs_zero) begin
                    quo_r     <= '1;  // rem_r keeps the raw dividend
                    quo_neg_r <= 1'b0;
                    rem_neg_r <= 1'b0;
                end else begin
                    rem_r <= '0;
                    quo_r <= dvd_mag;  // shifted out msb first
                    dvs_r <= dvs_mag;
                end
                cnt_r <= DIV_CNT_W'(DIV_STEPS - 1);
            end
            DIV_EXEC: begin
                rem_r <= (q_bit) ? diff[XLEN-1:0] : shifted[XLEN-1:0];
                quo_r <= {quo_r[XLEN-2:0], q_bit};
                cnt_r <= cnt_r - DIV_CNT_W'(1);
            end
            default: ;
        endcase
    end

    assign quo_out = (quo_neg_r) ? (~quo_r + XLEN'(1)) : quo_r;
    assign rem_out = (rem_neg_r) ? (~rem_r + XLEN'(1)) : rem_r;

    assign done_o = (state_r == DIV_RET);
    assign rslt_o = (!done_o) ? '0 : (rem_sel_r) ? rem_out : quo_out;

endmodule

`default_nettype wire

// ==== hw/muldiv/muldiv_unit.sv ====
//--------------------------------------------------------------------------
// RV32M multiply and divide unit, control plus the two sequential cores
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module muldiv_unit import muldiv_pkg::*; (
    input  wire              clk_i,
    input  wire              rst,
    input  wire              valid_i,
    input  wire muldiv_op_e  op_i,
    input  wire [XLEN-1:0]   src1_i,
    input  wire [XLEN-1:0]   src2_i,
    output wire              busy_o,
    output wire              done_o,
    output wire [XLEN-1:0]   rslt_o
);

    wire            mul_start;
    wire            mul_src1_signed;
    wire            mul_src2_signed;
    wire            mul_high;
    wire            mul_done;
    wire [XLEN-1:0] mul_rslt;
    wire            div_start;
    wire            div_signed;
    wire            div_rem;
    wire            div_done;
    wire [XLEN-1:0] div_rslt;

    muldiv_ctrl u_ctrl (
        .clk_i            (clk_i),
        .rst              (rst),
        .valid_i          (valid_i),
        .op_i             (op_i),
        .mul_done_i       (mul_done),
        .div_done_i       (div_done),
        .mul_rslt_i       (mul_rslt),
        .div_rslt_i       (div_rslt),
        .mul_start_o      (mul_start),
        .mul_src1_signed_o(mul_src1_signed),
        .mul_src2_signed_o(mul_src2_signed),
        .mul_high_o       (mul_high),
        .div_start_o      (div_start),
        .div_signed_o     (div_signed),
        .div_rem_o        (div_rem),
        .busy_o           (busy_o),
        .done_o           (done_o),
        .rslt_o           (rslt_o)
    );

    mul_core u_mul (
        .clk_i        (clk_i),
        .rst          (rst),
        .start_i      (mul_start),
        .src1_signed_i(mul_src1_signed),
        .src2_signed_i(mul_src2_signed),
        .high_i       (mul_high),
        .src1_i       (src1_i),
        .src2_i       (src2_i),
        .done_o       (mul_done),
        .rslt_o       (mul_rslt)
    );

    div_core u_div (
        .clk_i   (clk_i),
        .rst     (rst),
        .start_i (div_start),
        .signed_i(div_signed),
        .rem_i   (div_rem),
        .src1_i  (src1_i),
        .src2_i  (src2_i),
        .done_o  (div_done),
        .rslt_o  (div_rslt)
    );

endmodule

`default_nettype wire

// ==== test/muldiv_props.sv ====
//--------------------------------------------------------------------------
// muldiv strobe protocol assertions, bound to the unit top
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module muldiv_props import muldiv_pkg::*; (
    input wire            clk_i,
    input wire            rst,
    input wire            busy_i,
    input wire            done_i,
    input wire [XLEN-1:0] rslt_i
);

    int assert_fails = 0;  // read by the testbench at the end

    done_single: assert property (@(posedge clk_i) disable iff (rst)
        done_i |=> !done_i)
    else begin
        assert_fails++;
        $error("done_o high for two cycles in a row");
    end

    done_busy: assert property (@(posedge clk_i) disable iff (rst)
        done_i |-> busy_i)
    else begin
        assert_fails++;
        $error("done_o without busy_o");
    end

    reset_idle: assert property (@(posedge clk_i)
        rst |=> (!busy_i && !done_i))
    else begin
        assert_fails++;
        $error("busy_o or done_o high after reset");
    end

    rslt_quiet: assert property (@(posedge clk_i) disable iff (rst)
        !done_i |-> (rslt_i == '0))
    else begin
        assert_fails++;
        $error("rslt_o nonzero outside the done cycle");
    end

endmodule

bind muldiv_unit muldiv_props u_props (
    .clk_i (clk_i),
    .rst   (rst),
    .busy_i(busy_o),
    .done_i(done_o),
    .rslt_i(rslt_o)
);

`default_nettype wire

// ==== test/muldiv_tb.sv ====
//--------------------------------------------------------------------------
// muldiv unit testbench
// directed and seeded random RV32M operations checked against a reference
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module muldiv_tb import muldiv_pkg::*; ();

    localparam int CLK_HALF     = 4;             // 8 ns period
    localparam int SEED         = 8;
    localparam int MUL_LAT      = 2;             // edges from accept to done
    localparam int DIV_LAT      = DIV_STEPS + 2; // check step plus iterations
    localparam int ZERO_DIV_LAT = 2;
    localparam int N_CORNER     = 4;
    localparam int N_MUL_RAND   = 20;
    localparam int N_DIV_RAND   = 16;
    localparam int MUL_OPS      = 4 * N_CORNER * N_CORNER + 4 * N_MUL_RAND + 3;
    localparam int DIV_OPS      = 4 * N_DIV_RAND + 16 + 3;
    localparam int TIMEOUT_CYCLES =
        ((MUL_OPS * (MUL_LAT + 1) + DIV_OPS * (DIV_LAT + 1) + 16) * 5) / 2;
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic            clk_i;
    logic            rst;
    logic            valid_i;
    muldiv_op_e      op_i;
    logic [XLEN-1:0] src1_i;
    logic [XLEN-1:0] src2_i;
    wire             busy_o;
    wire             done_o;
    wire [XLEN-1:0]  rslt_o;

    int err_cnt;
    int check_cnt;
    int tests_run;
    int cycle_cnt;

    muldiv_unit DUT (
        .clk_i  (clk_i),
        .rst    (rst),
        .valid_i(valid_i),
        .op_i   (op_i),
        .src1_i (src1_i),
        .src2_i (src2_i),
        .busy_o (busy_o),
        .done_o (done_o),
        .rslt_o (rslt_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #CLK_HALF clk_i = ~clk_i;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    //----------------------------------------------------------------------
    // reference model from the RV32M rules
    //----------------------------------------------------------------------
    function automatic logic [XLEN-1:0] ref_result(input muldiv_op_e op,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0]      a_sx;
        logic [2*XLEN-1:0]      b_sx;
        logic [2*XLEN-1:0]      a_zx;
        logic [2*XLEN-1:0]      b_zx;
        logic [2*XLEN-1:0]      prod;
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic [XLEN-1:0]        res;
        logic                   div_zero;
        logic                   ovf;
        a_sx     = {{XLEN{a[XLEN-1]}}, a};
        b_sx     = {{XLEN{b[XLEN-1]}}, b};
        a_zx     = {{XLEN{1'b0}}, a};
        b_zx     = {{XLEN{1'b0}}, b};
        sa       = a;
        sb       = b;
        div_zero = (b == '0);
        ovf      = (a == MOST_NEG) && (b == '1);  // signed overflow pair
        res      = '0;
        case (op)
            OP_MUL: begin
                prod = a_zx * b_zx;
                res  = prod[XLEN-1:0];
            end
            OP_MULH: begin
                prod = a_sx * b_sx;  // mod 2^64 keeps the signed high word
                res  = prod[2*XLEN-1:XLEN];
            end
            OP_MULHSU: begin
                prod = a_sx * b_zx;
                res  = prod[2*XLEN-1:XLEN];
            end
            OP_MULHU: begin
                prod = a_zx * b_zx;
                res  = prod[2*XLEN-1:XLEN];
            end
            OP_DIV:  res = div_zero ? '1 : ovf ? MOST_NEG : $unsigned(sa / sb);
            OP_DIVU: res = div_zero ? '1 : a / b;
            OP_REM:  res = div_zero ? a : ovf ? '0 : $unsigned(sa % sb);  // sign of dividend
            OP_REMU: res = div_zero ? a : a % b;
            default: res = '0;
        endcase
        return res;
    endfunction

    function automatic int expected_latency(input muldiv_op_e op,
                                            input logic [XLEN-1:0] divisor);
        if (!op[2]) begin
            return MUL_LAT;  // funct3 msb clear means multiply
        end
        if (divisor == '0) begin
            return ZERO_DIV_LAT;
        end
        return DIV_LAT;
    endfunction

    function automatic logic [XLEN-1:0] corner_value(input int idx);
        case (idx)
            0:       return '0;
            1:       return 32'd1;
            2:       return '1;
            default: return MOST_NEG;
        endcase
    endfunction

    //----------------------------------------------------------------------
    // drive and observe
    //----------------------------------------------------------------------
    // called just after the accepting edge, returns at the done negedge
    task automatic wait_done(input int max_lat, output int lat,
                             output logic [XLEN-1:0] rslt, output bit got);
        got  = 1'b0;
        lat  = 0;
        rslt = '0;
        while (!got && lat < max_lat) begin
            @(negedge clk_i);
            lat++;
            valid_i = 1'b0;
            if (busy_o !== 1'b1) begin
                err_cnt++;
                $display("%0t: busy_o low while an operation is in flight", $time);
            end
            if (done_o === 1'b1) begin
                got  = 1'b1;
                rslt = rslt_o;
            end else begin
                if (rslt_o !== '0) begin
                    err_cnt++;
                    $display("ERR %0t: rslt_o %h outside the done cycle", $time, rslt_o);
                end
                @(posedge clk_i);
            end
        end
    endtask

    task automatic issue_and_check(input muldiv_op_e op, input logic [XLEN-1:0] a,
                                   input logic [XLEN-1:0] b);
        logic [XLEN-1:0] exp_rslt;
        logic [XLEN-1:0] got_rslt;
        int              exp_lat;
        int              lat;
        bit              got;
        exp_rslt = ref_result(op, a, b);
        exp_lat  = expected_latency(op, b);
        @(negedge clk_i);
        if (busy_o !== 1'b0) begin
            err_cnt++;
            $display("%0t: unit still busy when %s was presented", $time, op.name());
        end
        valid_i = 1'b1;
        op_i    = op;
        src1_i  = a;
        src2_i  = b;
        @(posedge clk_i);  // accepting edge
        wait_done(DIV_LAT + 4, lat, got_rslt, got);
        check_cnt++;
        if (!got) begin
            err_cnt++;
            $display("%0t: no done pulse for %s within %0d cycles", $time, op.name(),
                     DIV_LAT + 4);
        end else begin
            if (got_rslt !== exp_rslt) begin
                err_cnt++;
                $display("ERR %0t: %s %h, %h gave %h, expected %h", $time, op.name(),
                         a, b, got_rslt, exp_rslt);
            end
            if (lat != exp_lat) begin
                err_cnt++;
                $display("ERR %0t: %s done after %0d edges, expected %0d", $time,
                         op.name(), lat, exp_lat);
            end
        end
    endtask

    task automatic finish_test(input string name, input int errs_before,
                               input int checks_before);
        tests_run++;
        $display("%-22s %4d checks, %0d errors", name, check_cnt - checks_before,
                 err_cnt - errs_before);
    endtask

    //----------------------------------------------------------------------
    // tests
    //----------------------------------------------------------------------
    task automatic reset_state_check();
        int errs0;
        int chk0;
        errs0 = err_cnt;
        chk0  = check_cnt;
        repeat (2) begin
            check_cnt++;
            if (busy_o !== 1'b0 || done_o !== 1'b0 || rslt_o !== '0) begin
                err_cnt++;
                $display("ERR %0t: after reset busy %b done %b rslt %h", $time,
                         busy_o, done_o, rslt_o);
            end
            @(negedge clk_i);
        end
        finish_test("reset_state_check", errs0, chk0);
    endtask

    task automatic mul_corner_cases();
        int errs0;
        int chk0;
        errs0 = err_cnt;
        chk0  = check_cnt;
        for (int i = 0; i < N_CORNER; i++) begin
            for (int j = 0; j < N_CORNER; j++) begin
                for (int k = 0; k < 4; k++) begin
                    issue_and_check(muldiv_op_e'(k), corner_value(i), corner_value(j));
                end
            end
        end
        finish_test("mul_corner_cases", errs0, chk0);
    endtask

    task automatic mul_random_pairs();
        int              errs0;
        int              chk0;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        errs0 = err_cnt;
        chk0  = check_cnt;
        for (int i = 0; i < N_MUL_RAND; i++) begin
            a = $urandom;
            b = $urandom;
            for (int k = 0; k < 4; k++) begin
                issue_and_check(muldiv_op_e'(k), a, b);
            end
        end
        finish_test("mul_random_pairs", errs0, chk0);
    endtask

    task automatic div_random_pairs();
        int              errs0;
        int              chk0;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        errs0 = err_cnt;
        chk0  = check_cnt;
        for (int i = 0; i < N_DIV_RAND; i++) begin
            a = $urandom;
            b = $urandom;
            if (i % 2 == 1) b = b >> b[4:0];  // smaller divisors, wider quotients
            if (b == '0) b = 32'd3;
            for (int k = 0; k < 4; k++) begin
                issue_and_check(muldiv_op_e'(4 + k), a, b);
            end
        end
        finish_test("div_random_pairs", errs0, chk0);
    endtask

    task automatic div_special_cases();
        int              errs0;
        int              chk0;
        logic [XLEN-1:0] dvd [3];
        errs0  = err_cnt;
        chk0   = check_cnt;
        dvd[0] = 32'h1234_5678;
        dvd[1] = MOST_NEG;
        dvd[2] = '1;
        for (int i = 0; i < 3; i++) begin
            for (int k = 0; k < 4; k++) begin
                issue_and_check(muldiv_op_e'(4 + k), dvd[i], '0);  // zero divisor
            end
        end
        for (int k = 0; k < 4; k++) begin
            issue_and_check(muldiv_op_e'(4 + k), MOST_NEG, '1);
        end
        finish_test("div_special_cases", errs0, chk0);
    endtask

    task automatic busy_request_ignored();
        int              errs0;
        int              chk0;
        int              lat;
        bit              got;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] exp_rslt;
        logic [XLEN-1:0] got_rslt;
        errs0    = err_cnt;
        chk0     = check_cnt;
        a        = 32'hDEAD_BEEF;
        b        = 32'h0000_1234;
        exp_rslt = ref_result(OP_DIV, a, b);
        got      = 1'b0;
        lat      = 0;
        got_rslt = '0;
        @(negedge clk_i);
        valid_i = 1'b1;
        op_i    = OP_DIV;
        src1_i  = a;
        src2_i  = b;
        @(posedge clk_i);
        while (!got && lat < DIV_LAT + 4) begin
            @(negedge clk_i);
            lat++;
            if (lat == 1) begin
                op_i   = OP_MULHU;  // competing request, valid stays high
                src1_i = 32'h0F0F_0F0F;
                src2_i = 32'h7777_7777;
            end
            if (done_o === 1'b1) begin
                got      = 1'b1;
                got_rslt = rslt_o;
            end else begin
                @(posedge clk_i);
            end
        end
        valid_i = 1'b0;
        check_cnt++;
        if (!got) begin
            err_cnt++;
            $display("%0t: divide never finished while a request was held", $time);
        end else if (got_rslt !== exp_rslt || lat != DIV_LAT) begin
            err_cnt++;
            $display("ERR %0t: held divide gave %h after %0d edges, expected %h",
                     $time, got_rslt, lat, exp_rslt);
        end
        repeat (4) begin
            @(negedge clk_i);
            check_cnt++;
            if (done_o !== 1'b0 || busy_o !== 1'b0) begin
                err_cnt++;
                $display("%0t: ignored request started an operation", $time);
            end
        end
        issue_and_check(OP_MULHU, 32'h0F0F_0F0F, 32'h7777_7777);
        finish_test("busy_request_ignored", errs0, chk0);
    endtask

    task automatic mul_after_div();
        int errs0;
        int chk0;
        errs0 = err_cnt;
        chk0  = check_cnt;
        // each issue drives at the first negedge after the previous done
        issue_and_check(OP_REM, 32'h8765_4321, 32'h0000_0035);
        issue_and_check(OP_MUL, 32'hFFFF_FFF9, 32'h0001_0003);
        issue_and_check(OP_DIVU, 32'hFFFF_0000, 32'h0000_00FF);
        issue_and_check(OP_MULH, MOST_NEG, 32'h7FFF_FFFF);
        finish_test("mul_after_div", errs0, chk0);
    endtask

    //----------------------------------------------------------------------
    // main sequence
    //----------------------------------------------------------------------
    initial begin
        int total_errs;
        void'($urandom(SEED));
        err_cnt   = 0;
        check_cnt = 0;
        tests_run = 0;
        rst       = 1'b1;
        valid_i   = 1'b0;
        op_i      = OP_MUL;
        src1_i    = '0;
        src2_i    = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst = 1'b0;
        reset_state_check();
        mul_corner_cases();
        mul_random_pairs();
        div_random_pairs();
        div_special_cases();
        busy_request_ignored();
        mul_after_div();
        repeat (2) @(negedge clk_i);
        total_errs = err_cnt + DUT.u_props.assert_fails;
        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, check_cnt, err_cnt, DUT.u_props.assert_fails);
        if (total_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
common/muldiv_pkg.sv
hw/muldiv/muldiv_ctrl.sv
hw/muldiv/mul_core.sv
hw/muldiv/div_core.sv
hw/muldiv/muldiv_unit.sv
test/muldiv_props.sv
test/muldiv_tb.sv

// ==== Bender.yml ====
package:
  name: muldiv

sources:
  # shared package first, then the cores and the top
  - files:
      - common/muldiv_pkg.sv
      - hw/muldiv/muldiv_ctrl.sv
      - hw/muldiv/mul_core.sv
      - hw/muldiv/div_core.sv
      - hw/muldiv/muldiv_unit.sv

  - target: test
    files:
      - test/muldiv_props.sv
      - test/muldiv_tb.sv

# testbench top: muldiv_tb
# design top:    muldiv_unit
